// ==== saturn_pkg.sv ====
// sizes, register map addresses, instruction type and bus command encodings
`default_nettype none

package saturn_pkg;

    // nibble based data path sizes
    localparam int NIBBLE_W = 4;
    localparam int PC_NIBBLES = 5;
    localparam int C_NIBBLES = 16;
    localparam int ST_W = 16;

    // width of the counter that walks the nibbles of PC and C(A)
    localparam int PC_NIB_CNT_W = 3;

    // bus command program memory
    localparam int PROG_DEPTH = 32;
    localparam int PROG_ADDR_W = 5;
    localparam int PROG_ENTRY_W = 5;

    // host Wishbone port
    localparam int WB_ADR_W = 3;
    localparam int WB_DAT_W = 32;

    // word addresses of the register map
    localparam logic [WB_ADR_W-1:0] ADDR_INSTR = 3'd0;
    localparam logic [WB_ADR_W-1:0] ADDR_PC = 3'd1;
    localparam logic [WB_ADR_W-1:0] ADDR_STATUS = 3'd2;
    localparam logic [WB_ADR_W-1:0] ADDR_ST = 3'd3;
    localparam logic [WB_ADR_W-1:0] ADDR_C_LO = 3'd4;
    localparam logic [WB_ADR_W-1:0] ADDR_C_HI = 3'd5;
    localparam logic [WB_ADR_W-1:0] ADDR_D0 = 3'd6;

    // decoded instruction types, codes 11 to 15 are not supported
    typedef enum logic [3:0] {
        INSTR_NOP       = 4'd0,
        INSTR_SET_P     = 4'd1,
        INSTR_C_EQ_P    = 4'd2,
        INSTR_CLR_HST   = 4'd3,
        INSTR_SET_ST    = 4'd4,
        INSTR_SET_MODE  = 4'd5,
        INSTR_SET_CARRY = 4'd6,
        INSTR_LOAD_C    = 4'd7,
        INSTR_LOAD_D0   = 4'd8,
        INSTR_CONFIG    = 4'd9,
        INSTR_RESET     = 4'd10
    } instr_type_e;

    // command codes placed in the bus program with the command bit set
    typedef enum logic [3:0] {
        BUSCMD_PC_READ   = 4'd0,
        BUSCMD_LOAD_PC   = 4'd4,
        BUSCMD_CONFIGURE = 4'd6,
        BUSCMD_RESET     = 4'd15
    } buscmd_e;

endpackage

`default_nettype wire

// ==== saturn_wb_regs.sv ====
// Wishbone slave with address decode, instruction hand-off, PC register and readback mux
`timescale 1ns/1ps
`default_nettype none

module saturn_wb_regs import saturn_pkg::*; (
    input  logic                                    i_clk,
    input  logic                                    i_reset,
    input  logic                                    i_wb_cyc,
    input  logic                                    i_wb_stb,
    input  logic                                    i_wb_we,
    input  logic [WB_ADR_W-1:0]                     i_wb_adr,
    input  logic [WB_DAT_W-1:0]                     i_wb_dat,
    input  logic                                    i_seq_busy,
    input  logic [NIBBLE_W-1:0]                     i_reg_p,
    input  logic [NIBBLE_W-1:0]                     i_reg_hst,
    input  logic                                    i_carry,
    input  logic                                    i_mode,
    input  logic                                    i_error,
    input  logic [ST_W-1:0]                         i_reg_st,
    input  logic [C_NIBBLES-1:0][NIBBLE_W-1:0]      i_reg_c,
    input  logic [PC_NIBBLES-1:0][NIBBLE_W-1:0]     i_reg_d0,
    output logic [WB_DAT_W-1:0]                     o_wb_dat,
    output logic                                    o_wb_ack,
    output logic                                    o_instr_valid,
    output instr_type_e                             o_instr_type,
    output logic [NIBBLE_W-1:0]                     o_instr_ptr,
    output logic [NIBBLE_W-1:0]                     o_instr_imm,
    output logic [PC_NIBBLES-1:0][NIBBLE_W-1:0]     o_pc,
    output logic                                    o_pc_load
);

    logic write_ack;

    // one ack per request, held back while a bus stream is being written
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= i_wb_cyc && i_wb_stb && !o_wb_ack && !i_seq_busy;
        end
    end

    assign write_ack = o_wb_ack && i_wb_we;

    // the master keeps the write data stable through the ack cycle
    assign o_instr_valid = write_ack && (i_wb_adr == ADDR_INSTR);
    assign o_pc_load = write_ack && (i_wb_adr == ADDR_PC);

    assign o_instr_type = instr_type_e'(i_wb_dat[3:0]);
    assign o_instr_ptr = i_wb_dat[7:4];
    assign o_instr_imm = i_wb_dat[11:8];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pc <= '0;
        end else if (o_pc_load) begin
            o_pc <= i_wb_dat[PC_NIBBLES*NIBBLE_W-1:0];
        end
    end

    // readback, unused upper bits read as zero
    always_comb begin
        o_wb_dat = '0;
        case (i_wb_adr)
            ADDR_PC: begin
                o_wb_dat[PC_NIBBLES*NIBBLE_W-1:0] = o_pc;
            end
            ADDR_STATUS: begin
                o_wb_dat[3:0] = i_reg_p;
                o_wb_dat[7:4] = i_reg_hst;
                o_wb_dat[8] = i_carry;
                o_wb_dat[9] = i_mode;
                o_wb_dat[10] = i_error;
            end
            ADDR_ST: begin
                o_wb_dat[ST_W-1:0] = i_reg_st;
            end
            ADDR_C_LO: begin
                o_wb_dat = i_reg_c[7:0];
            end
            ADDR_C_HI: begin
                o_wb_dat = i_reg_c[15:8];
            end
            ADDR_D0: begin
                o_wb_dat[PC_NIBBLES*NIBBLE_W-1:0] = i_reg_d0;
            end
            default: begin
                o_wb_dat = '0;
            end
        endcase
    end

    // an ack must never outlive the request it answers
    assert property (@(posedge i_clk) disable iff (i_reset)
        o_wb_ack |-> (i_wb_cyc && i_wb_stb));

endmodule

`default_nettype wire

// ==== saturn_exec_unit.sv ====
// instruction execution on P, ST, HST, carry, mode, C and D0 with sticky error flag
`timescale 1ns/1ps
`default_nettype none

module saturn_exec_unit import saturn_pkg::*; (
    input  logic                                    i_clk,
    input  logic                                    i_reset,
    input  logic                                    i_instr_valid,
    input  instr_type_e                             i_instr_type,
    input  logic [NIBBLE_W-1:0]                     i_instr_ptr,
    input  logic [NIBBLE_W-1:0]                     i_instr_imm,
    output logic [NIBBLE_W-1:0]                     o_reg_p,
    output logic [NIBBLE_W-1:0]                     o_reg_hst,
    output logic                                    o_carry,
    output logic                                    o_mode,
    output logic [ST_W-1:0]                         o_reg_st,
    output logic [C_NIBBLES-1:0][NIBBLE_W-1:0]      o_reg_c,
    output logic [PC_NIBBLES-1:0][NIBBLE_W-1:0]     o_reg_d0,
    output logic                                    o_error,
    output logic                                    o_start_config,
    output logic                                    o_start_reset
);

    logic d0_ptr_ok;

    // D0 only has nibbles 0 to 4
    assign d0_ptr_ok = (i_instr_ptr <= NIBBLE_W'(PC_NIBBLES - 1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_reg_p <= '0;
            o_reg_hst <= '0;
            o_carry <= 1'b0;
            o_mode <= 1'b0;
            o_reg_st <= '0;
            o_reg_c <= '0;
            o_reg_d0 <= '0;
            o_error <= 1'b0;
        end else if (i_instr_valid) begin
            case (i_instr_type)
                INSTR_NOP: begin
                end
                INSTR_SET_P: begin
                    o_reg_p <= i_instr_imm;
                end
                INSTR_C_EQ_P: begin
                    o_reg_c[i_instr_ptr] <= o_reg_p;
                end
                INSTR_CLR_HST: begin
                    // each set bit of n clears the matching HST flag
                    o_reg_hst <= o_reg_hst & ~i_instr_imm;
                end
                INSTR_SET_ST: begin
                    o_reg_st[i_instr_ptr] <= i_instr_imm[0];
                end
                INSTR_SET_MODE: begin
                    o_mode <= i_instr_imm[0];
                end
                INSTR_SET_CARRY: begin
                    o_carry <= i_instr_imm[0];
                end
                INSTR_LOAD_C: begin
                    o_reg_c[i_instr_ptr] <= i_instr_imm;
                end
                INSTR_LOAD_D0: begin
                    if (d0_ptr_ok) begin
                        o_reg_d0[i_instr_ptr[PC_NIB_CNT_W-1:0]] <= i_instr_imm;
                    end else begin
                        o_error <= 1'b1;
                    end
                end
                INSTR_CONFIG, INSTR_RESET: begin
                    // handled by the bus sequencer through the start pulses
                end
                default: begin
                    o_error <= 1'b1;
                end
            endcase
        end
    end

    assign o_start_config = i_instr_valid && (i_instr_type == INSTR_CONFIG);
    assign o_start_reset = i_instr_valid && (i_instr_type == INSTR_RESET);

    assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_start_config && o_start_reset));

endmodule

`default_nettype wire

// ==== saturn_bus_sequencer.sv ====
// bus program memory and the FSM that writes command and nibble streams into it
`timescale 1ns/1ps
`default_nettype none

module saturn_bus_sequencer import saturn_pkg::*; (
    input  logic                                    i_clk,
    input  logic                                    i_reset,
    input  logic [PC_NIBBLES-1:0][NIBBLE_W-1:0]     i_pc,
    input  logic                                    i_pc_load,
    input  logic                                    i_start_config,
    input  logic                                    i_start_reset,
    input  logic [PC_NIBBLES-1:0][NIBBLE_W-1:0]     i_reg_c_a,
    input  logic [PROG_ADDR_W-1:0]                  i_prog_rd_addr,
    output logic                                    o_seq_busy,
    output logic [PROG_ENTRY_W-1:0]                 o_prog_data,
    output logic [PROG_ADDR_W-1:0]                  o_prog_wr_addr
);

    typedef enum logic [2:0] {
        POWER_UP,
        IDLE,
        LOAD_PC_NIB,
        CFG_NIB,
        PC_READ_CMD
    } seq_state_e;

    seq_state_e state;
    logic [PC_NIB_CNT_W-1:0] nib_cnt;
    logic [PROG_ADDR_W-1:0] wr_ptr;
    logic lead_pend;
    buscmd_e lead_cmd;
    logic [PC_NIBBLES-1:0][NIBBLE_W-1:0] c_a_q;
    logic last_nib;
    logic prog_we;
    logic [PROG_ENTRY_W-1:0] prog_wdata;
    logic [PROG_ENTRY_W-1:0] prog_mem [PROG_DEPTH];

    assign last_nib = (nib_cnt == PC_NIB_CNT_W'(PC_NIBBLES - 1));
    assign o_seq_busy = (state != IDLE);
    assign o_prog_wr_addr = wr_ptr;

    // every state except IDLE writes exactly one entry per clock
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= POWER_UP;
            nib_cnt <= '0;
            wr_ptr <= '0;
            lead_pend <= 1'b0;
        end else begin
            if (prog_we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            case (state)
                POWER_UP: begin
                    nib_cnt <= '0;
                    state <= LOAD_PC_NIB;
                end
                IDLE: begin
                    nib_cnt <= '0;
                    lead_pend <= i_pc_load || i_start_config || i_start_reset;
                    if (i_pc_load) begin
                        state <= LOAD_PC_NIB;
                    end else if (i_start_config) begin
                        state <= CFG_NIB;
                    end else if (i_start_reset) begin
                        state <= PC_READ_CMD;
                    end
                end
                LOAD_PC_NIB, CFG_NIB: begin
                    if (lead_pend) begin
                        lead_pend <= 1'b0;
                    end else begin
                        nib_cnt <= nib_cnt + 1'b1;
                        if (last_nib) begin
                            state <= (state == CFG_NIB) ? PC_READ_CMD : IDLE;
                        end
                    end
                end
                default: begin
                    // RESET is written first when it is pending, then PC_READ
                    if (lead_pend) begin
                        lead_pend <= 1'b0;
                    end else begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // leading command and C(A) are captured when the trigger is taken
    always_ff @(posedge i_clk) begin
        if (state == IDLE) begin
            c_a_q <= i_reg_c_a;
            if (i_pc_load) begin
                lead_cmd <= BUSCMD_LOAD_PC;
            end else if (i_start_config) begin
                lead_cmd <= BUSCMD_CONFIGURE;
            end else begin
                lead_cmd <= BUSCMD_RESET;
            end
        end
    end

    // the PC register already holds the new value once the stream starts,
    // and it cannot change again before the stream ends
    always_comb begin
        case (state)
            POWER_UP:    prog_wdata = {1'b1, BUSCMD_LOAD_PC};
            LOAD_PC_NIB: prog_wdata = lead_pend ? {1'b1, lead_cmd} : {1'b0, i_pc[nib_cnt]};
            CFG_NIB:     prog_wdata = lead_pend ? {1'b1, lead_cmd} : {1'b0, c_a_q[nib_cnt]};
            PC_READ_CMD: prog_wdata = lead_pend ? {1'b1, lead_cmd} : {1'b1, BUSCMD_PC_READ};
            default:     prog_wdata = '0;
        endcase
    end

    assign prog_we = (state != IDLE) && !i_reset;

    always_ff @(posedge i_clk) begin
        if (prog_we) begin
            prog_mem[wr_ptr] <= prog_wdata;
        end
    end

    assign o_prog_data = prog_mem[i_prog_rd_addr];

    // the Wishbone side must hold off new work until the stream is done
    assert property (@(posedge i_clk) disable iff (i_reset)
        (i_pc_load || i_start_config || i_start_reset) |-> !o_seq_busy);

endmodule

`default_nettype wire

// ==== saturn_control_unit.sv ====
// top level joining the Wishbone register block, execution unit and bus sequencer
`timescale 1ns/1ps
`default_nettype none

module saturn_control_unit import saturn_pkg::*; (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_wb_cyc,
    input  logic                        i_wb_stb,
    input  logic                        i_wb_we,
    input  logic [WB_ADR_W-1:0]         i_wb_adr,
    input  logic [WB_DAT_W-1:0]         i_wb_dat,
    input  logic [PROG_ADDR_W-1:0]      i_prog_rd_addr,
    output logic [WB_DAT_W-1:0]         o_wb_dat,
    output logic                        o_wb_ack,
    output logic [PROG_ENTRY_W-1:0]     o_prog_data,
    output logic [PROG_ADDR_W-1:0]      o_prog_wr_addr,
    output logic                        o_error
);

    logic seq_busy;
    logic instr_valid;
    instr_type_e instr_type;
    logic [NIBBLE_W-1:0] instr_ptr;
    logic [NIBBLE_W-1:0] instr_imm;
    logic [PC_NIBBLES-1:0][NIBBLE_W-1:0] pc;
    logic pc_load;
    logic [NIBBLE_W-1:0] reg_p;
    logic [NIBBLE_W-1:0] reg_hst;
    logic carry;
    logic mode;
    logic [ST_W-1:0] reg_st;
    logic [C_NIBBLES-1:0][NIBBLE_W-1:0] reg_c;
    logic [PC_NIBBLES-1:0][NIBBLE_W-1:0] reg_d0;
    logic start_config;
    logic start_reset;

    saturn_wb_regs saturn_wb_regs_inst (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_wb_adr       (i_wb_adr),
        .i_wb_dat       (i_wb_dat),
        .i_seq_busy     (seq_busy),
        .i_reg_p        (reg_p),
        .i_reg_hst      (reg_hst),
        .i_carry        (carry),
        .i_mode         (mode),
        .i_error        (o_error),
        .i_reg_st       (reg_st),
        .i_reg_c        (reg_c),
        .i_reg_d0       (reg_d0),
        .o_wb_dat       (o_wb_dat),
        .o_wb_ack       (o_wb_ack),
        .o_instr_valid  (instr_valid),
        .o_instr_type   (instr_type),
        .o_instr_ptr    (instr_ptr),
        .o_instr_imm    (instr_imm),
        .o_pc           (pc),
        .o_pc_load      (pc_load)
    );

    saturn_exec_unit saturn_exec_unit_inst (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_instr_valid  (instr_valid),
        .i_instr_type   (instr_type),
        .i_instr_ptr    (instr_ptr),
        .i_instr_imm    (instr_imm),
        .o_reg_p        (reg_p),
        .o_reg_hst      (reg_hst),
        .o_carry        (carry),
        .o_mode         (mode),
        .o_reg_st       (reg_st),
        .o_reg_c        (reg_c),
        .o_reg_d0       (reg_d0),
        .o_error        (o_error),
        .o_start_config (start_config),
        .o_start_reset  (start_reset)
    );

    // C(A) is the low five nibbles of C
    saturn_bus_sequencer saturn_bus_sequencer_inst (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_pc           (pc),
        .i_pc_load      (pc_load),
        .i_start_config (start_config),
        .i_start_reset  (start_reset),
        .i_reg_c_a      (reg_c[PC_NIBBLES-1:0]),
        .i_prog_rd_addr (i_prog_rd_addr),
        .o_seq_busy     (seq_busy),
        .o_prog_data    (o_prog_data),
        .o_prog_wr_addr (o_prog_wr_addr)
    );

endmodule

`default_nettype wire

// ==== tb_saturn_control_unit.sv ====
// testbench for the control unit with host bus tasks, reference model, assertions and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_saturn_control_unit import saturn_pkg::*; ();

    // about 330 host transfers of three cycles each, the stream stalls and the
    // program scans take some 1200 cycles
    localparam int TIMEOUT_CYCLES = 5000;

    logic i_clk;
    logic i_reset;
    logic i_wb_cyc;
    logic i_wb_stb;
    logic i_wb_we;
    logic [WB_ADR_W-1:0] i_wb_adr;
    logic [WB_DAT_W-1:0] i_wb_dat;
    logic [PROG_ADDR_W-1:0] i_prog_rd_addr;
    logic [WB_DAT_W-1:0] o_wb_dat;
    logic o_wb_ack;
    logic [PROG_ENTRY_W-1:0] o_prog_data;
    logic [PROG_ADDR_W-1:0] o_prog_wr_addr;
    logic o_error;

    // reference model of the registers and of the bus program
    logic [NIBBLE_W-1:0] exp_p;
    logic [NIBBLE_W-1:0] exp_hst;
    logic exp_carry;
    logic exp_mode;
    logic exp_error;
    logic [ST_W-1:0] exp_st;
    logic [C_NIBBLES*NIBBLE_W-1:0] exp_c;
    logic [PC_NIBBLES*NIBBLE_W-1:0] exp_d0;
    logic [PC_NIBBLES*NIBBLE_W-1:0] exp_pc;
    logic [PROG_ENTRY_W-1:0] exp_prog [PROG_DEPTH];
    logic exp_valid [PROG_DEPTH];
    logic [PROG_ADDR_W-1:0] exp_wr_ptr;

    logic [31:0] lcg_state;
    logic [PROG_ADDR_W-1:0] ack_wr_addr;
    int cycle_count = 0;

    saturn_control_unit saturn_control_unit_inst (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_wb_adr       (i_wb_adr),
        .i_wb_dat       (i_wb_dat),
        .i_prog_rd_addr (i_prog_rd_addr),
        .o_wb_dat       (o_wb_dat),
        .o_wb_ack       (o_wb_ack),
        .o_prog_data    (o_prog_data),
        .o_prog_wr_addr (o_prog_wr_addr),
        .o_error        (o_error)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            fail_run($sformatf("error at %0t ns: %s expected 0x%0h actual 0x%0h",
                               $time, name, expected, actual));
        end
    endtask

    // every ack lasts exactly one cycle
    assert property (@(posedge i_clk) disable iff (i_reset) o_wb_ack |=> !o_wb_ack)
        else fail_run("o_wb_ack stayed high for more than one cycle");

    // once raised the error flag holds until the next reset
    assert property (@(posedge i_clk) disable iff (i_reset) o_error |=> o_error)
        else fail_run("o_error dropped without a reset");

    // a new ack only comes when no stream is being written
    assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(o_wb_ack) |-> $stable(o_prog_wr_addr))
        else fail_run("o_wb_ack was given while a bus stream was being written");

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [3:0] scalar_type(input int sel);
        case (sel)
            0: return INSTR_NOP;
            1: return INSTR_SET_P;
            2: return INSTR_CLR_HST;
            3: return INSTR_SET_ST;
            4: return INSTR_SET_MODE;
            default: return INSTR_SET_CARRY;
        endcase
    endfunction

    task automatic append_entry(input logic [PROG_ENTRY_W-1:0] entry);
        exp_prog[exp_wr_ptr] = entry;
        exp_valid[exp_wr_ptr] = 1'b1;
        exp_wr_ptr = exp_wr_ptr + 1'b1;
    endtask

    task automatic append_pc_stream(input logic [PC_NIBBLES*NIBBLE_W-1:0] pc);
        append_entry({1'b1, BUSCMD_LOAD_PC});
        for (int i = 0; i < PC_NIBBLES; i++) begin
            append_entry({1'b0, pc[i*NIBBLE_W +: NIBBLE_W]});
        end
    endtask

    // registers clear on reset, the program memory keeps its old contents
    task automatic clear_model();
        exp_p = '0;
        exp_hst = '0;
        exp_carry = 1'b0;
        exp_mode = 1'b0;
        exp_error = 1'b0;
        exp_st = '0;
        exp_c = '0;
        exp_d0 = '0;
        exp_pc = '0;
        exp_wr_ptr = '0;
        append_pc_stream(exp_pc);
    endtask

    task automatic model_exec(input logic [3:0] instr_type, input logic [3:0] ptr,
                              input logic [3:0] imm);
        int idx;
        idx = int'(ptr);
        case (instr_type)
            INSTR_NOP: begin
            end
            INSTR_SET_P: exp_p = imm;
            INSTR_C_EQ_P: exp_c[idx*NIBBLE_W +: NIBBLE_W] = exp_p;
            INSTR_CLR_HST: exp_hst = exp_hst & ~imm;
            INSTR_SET_ST: exp_st[idx] = imm[0];
            INSTR_SET_MODE: exp_mode = imm[0];
            INSTR_SET_CARRY: exp_carry = imm[0];
            INSTR_LOAD_C: exp_c[idx*NIBBLE_W +: NIBBLE_W] = imm;
            INSTR_LOAD_D0: begin
                if (idx < PC_NIBBLES) begin
                    exp_d0[idx*NIBBLE_W +: NIBBLE_W] = imm;
                end else begin
                    exp_error = 1'b1;
                end
            end
            INSTR_CONFIG: begin
                append_entry({1'b1, BUSCMD_CONFIGURE});
                for (int i = 0; i < PC_NIBBLES; i++) begin
                    append_entry({1'b0, exp_c[i*NIBBLE_W +: NIBBLE_W]});
                end
                append_entry({1'b1, BUSCMD_PC_READ});
            end
            INSTR_RESET: begin
                append_entry({1'b1, BUSCMD_RESET});
                append_entry({1'b1, BUSCMD_PC_READ});
            end
            default: exp_error = 1'b1;
        endcase
    endtask

    // called on a falling edge, holds the request through the ack cycle
    task automatic host_transfer(input logic we, input logic [WB_ADR_W-1:0] adr,
                                 input logic [WB_DAT_W-1:0] wdata,
                                 output logic [WB_DAT_W-1:0] rdata);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we = we;
        i_wb_adr = adr;
        i_wb_dat = wdata;
        @(negedge i_clk);
        while (!o_wb_ack) begin
            @(negedge i_clk);
        end
        rdata = o_wb_dat;
        ack_wr_addr = o_prog_wr_addr;
        @(negedge i_clk);
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we = 1'b0;
        @(negedge i_clk);
    endtask

    task automatic write_word(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] data);
        logic [WB_DAT_W-1:0] unused;
        host_transfer(1'b1, adr, data, unused);
    endtask

    task automatic read_word(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] data);
        host_transfer(1'b0, adr, '0, data);
    endtask

    task automatic exec_instr(input logic [3:0] instr_type, input logic [3:0] ptr,
                              input logic [3:0] imm);
        write_word(ADDR_INSTR, {20'd0, imm, ptr, instr_type});
        model_exec(instr_type, ptr, imm);
    endtask

    task automatic check_readbacks();
        logic [WB_DAT_W-1:0] data;
        read_word(ADDR_PC, data);
        check_value("pc readback", data, {12'd0, exp_pc});
        read_word(ADDR_STATUS, data);
        check_value("status readback", data,
                    {21'd0, exp_error, exp_mode, exp_carry, exp_hst, exp_p});
        read_word(ADDR_ST, data);
        check_value("st readback", data, {16'd0, exp_st});
        read_word(ADDR_C_LO, data);
        check_value("c_lo readback", data, exp_c[31:0]);
        read_word(ADDR_C_HI, data);
        check_value("c_hi readback", data, exp_c[63:32]);
        read_word(ADDR_D0, data);
        check_value("d0 readback", data, {12'd0, exp_d0});
        check_value("o_error", 32'(o_error), 32'(exp_error));
    endtask

    // waits for the stream to end, then scans every entry written so far
    task automatic check_program();
        while (o_prog_wr_addr !== exp_wr_ptr) begin
            @(negedge i_clk);
        end
        for (int idx = 0; idx < PROG_DEPTH; idx++) begin
            if (exp_valid[idx]) begin
                i_prog_rd_addr = PROG_ADDR_W'(idx);
                @(negedge i_clk);
                check_value($sformatf("o_prog_data[%0d]", idx), 32'(o_prog_data),
                            32'(exp_prog[idx]));
            end
        end
    endtask

    task automatic apply_reset();
        i_reset = 1'b1;
        repeat (10) @(negedge i_clk);
        i_reset = 1'b0;
        clear_model();
    endtask

    initial begin
        logic [31:0] rnd;
        logic [WB_DAT_W-1:0] data;
        int sel;
        i_reset = 1'b1;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we = 1'b0;
        i_wb_adr = '0;
        i_wb_dat = '0;
        i_prog_rd_addr = '0;
        lcg_state = 32'h249017c2;
        ack_wr_addr = '0;
        for (int i = 0; i < PROG_DEPTH; i++) begin
            exp_valid[i] = 1'b0;
        end

        apply_reset();
        check_value("o_error", 32'(o_error), 32'd0);
        check_program();
        check_value("o_prog_wr_addr", 32'(o_prog_wr_addr), 32'd6);
        check_readbacks();
        read_word(ADDR_INSTR, data);
        check_value("instr readback", data, 32'd0);

        // scalar registers
        for (int n = 0; n < 20; n++) begin
            rnd = next_random();
            sel = int'(rnd[30:16] % 15'd6);
            exec_instr(scalar_type(sel), rnd[7:4], rnd[11:8]);
            check_readbacks();
        end

        // C and D0 nibbles, D0 pointers kept in range
        for (int n = 0; n < 20; n++) begin
            rnd = next_random();
            sel = int'(rnd[30:16] % 15'd3);
            if (sel == 0) begin
                exec_instr(INSTR_LOAD_C, rnd[7:4], rnd[11:8]);
            end else if (sel == 1) begin
                exec_instr(INSTR_C_EQ_P, rnd[7:4], rnd[11:8]);
            end else begin
                exec_instr(INSTR_LOAD_D0, 4'(rnd[7:4] % 4'd5), rnd[11:8]);
            end
            check_readbacks();
        end

        // bus streams
        exec_instr(INSTR_CONFIG, 4'd0, 4'd0);
        check_program();
        exec_instr(INSTR_RESET, 4'd0, 4'd0);
        check_program();
        rnd = next_random();
        write_word(ADDR_PC, {12'd0, rnd[19:0]});
        exp_pc = rnd[19:0];
        append_pc_stream(exp_pc);
        check_program();
        check_readbacks();

        // a write right behind CONFIG stalls until all seven entries are in
        exec_instr(INSTR_CONFIG, 4'd0, 4'd0);
        rnd = next_random();
        exec_instr(INSTR_SET_P, 4'd0, rnd[3:0]);
        check_value("o_prog_wr_addr at ack", 32'(ack_wr_addr), 32'(exp_wr_ptr));
        check_program();
        check_readbacks();

        // error flag
        rnd = next_random();
        exec_instr(4'(32'd11 + rnd % 32'd5), rnd[7:4], rnd[11:8]);
        check_readbacks();
        exec_instr(INSTR_LOAD_D0, 4'd7, rnd[11:8]);
        check_readbacks();
        exec_instr(INSTR_SET_CARRY, 4'd0, 4'd1);
        check_readbacks();
        apply_reset();
        check_value("o_error", 32'(o_error), 32'd0);
        check_program();
        check_readbacks();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== saturn_control_unit.f ====
saturn_pkg.sv
saturn_wb_regs.sv
saturn_exec_unit.sv
saturn_bus_sequencer.sv
saturn_control_unit.sv
tb_saturn_control_unit.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert --timing -f saturn_control_unit.f \
		--top-module tb_saturn_control_unit -Mdir obj_dir -o sim_tb
	@out=$$(./obj_dir/sim_tb 2>&1); echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
